/* design/board_store.sv */
`timescale 1ns/1ps

module board_store (
    input  logic                              i_clk,
    input  logic                              i_rst_n,
    input  tetris_pkg::board_cmd_t            i_cmd,
    output tetris_pkg::board_t                o_board,
    output logic [tetris_pkg::FIELD_ROWS-1:0] o_row_full
);
    import tetris_pkg::*;

    board_t board_q;

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            board_q <= '0;
        end else begin
            case (i_cmd.op)
                OP_WIPE: begin
                    board_q <= '0;
                end
                OP_PLACE: begin
                    for (int k = 0; k < 4; k++) begin
                        board_q[i_cmd.cells[k].y][i_cmd.cells[k].x] <= i_cmd.code;
                    end
                end
                OP_CLEAR_ROW: begin
                    // rows at or above the cleared one move down
                    board_q[0] <= '0;
                    for (int r = 1; r < FIELD_ROWS; r++) begin
                        if (row_t'(r) <= i_cmd.row) begin
                            board_q[r] <= board_q[r-1];
                        end
                    end
                end
                default: begin
                end
            endcase
        end
    end

    always_comb begin
        for (int r = 0; r < FIELD_ROWS; r++) begin
            o_row_full[r] = 1'b1;
            for (int c = 0; c < FIELD_COLS; c++) begin
                if (board_q[r][c] == '0) begin
                    o_row_full[r] = 1'b0;
                end
            end
        end
    end

    assign o_board = board_q;

endmodule

/* design/field_renderer.sv */
`timescale 1ns/1ps

module field_renderer (
    input  logic                    i_clk,
    input  logic                    i_rst_n,
    input  logic [9:0]              i_x,
    input  logic [9:0]              i_y,
    input  tetris_pkg::board_t      i_board,
    input  tetris_pkg::cells_t      i_active_cells,
    input  tetris_pkg::color_code_t i_active_code,
    input  logic                    i_playing,
    output tetris_pkg::rgb_t        o_rgb
);
    import tetris_pkg::*;

    localparam int FIELD_X1 = FIELD_X0 + FIELD_COLS * CELL_W;
    localparam int FIELD_Y1 = FIELD_Y0 + FIELD_ROWS * CELL_H;

    logic [9:0]  rel_x;
    logic [9:0]  rel_y;
    logic        in_field;
    logic        on_grid;
    logic        in_cell;
    logic        on_piece;
    cell_t       pix_cell;
    color_code_t board_code;
    rgb_t        rgb_d;

    assign in_field = (i_x >= 10'(FIELD_X0)) && (i_x <= 10'(FIELD_X1))
                   && (i_y >= 10'(FIELD_Y0)) && (i_y <= 10'(FIELD_Y1));
    assign rel_x    = i_x - 10'(FIELD_X0);
    assign rel_y    = i_y - 10'(FIELD_Y0);
    assign on_grid  = (rel_x % 10'(CELL_W) == 10'd0) || (rel_y % 10'(CELL_H) == 10'd0);

    // pixel to cell
    assign pix_cell.x = col_t'(rel_x / 10'(CELL_W));
    assign pix_cell.y = row_t'(rel_y / 10'(CELL_H));
    assign in_cell    = (pix_cell.x < col_t'(FIELD_COLS)) && (pix_cell.y < row_t'(FIELD_ROWS));
    assign board_code = in_cell ? i_board[pix_cell.y][pix_cell.x] : '0;

    always_comb begin
        on_piece = 1'b0;
        for (int k = 0; k < 4; k++) begin
            if (i_playing && i_active_cells[k] == pix_cell) begin
                on_piece = 1'b1;
            end
        end
    end

    always_comb begin
        if (!in_field) begin
            rgb_d = '{BACK_LEVEL, BACK_LEVEL, BACK_LEVEL};
        end else if (on_grid) begin
            rgb_d = '{GRID_LEVEL, GRID_LEVEL, GRID_LEVEL};
        end else if (on_piece) begin
            rgb_d = PALETTE[i_active_code];
        end else begin
            rgb_d = PALETTE[board_code];
        end
    end

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_rgb <= '0;
        end else begin
            o_rgb <= rgb_d;
        end
    end

endmodule

/* design/piece_controller.sv */
`timescale 1ns/1ps

module piece_controller #(
    parameter int GRAVITY_TICKS = 1 << 24,
    parameter int SETTLE_TICKS  = 1 << 22
) (
    input  logic                              i_clk,
    input  logic                              i_rst_n,
    input  logic                              i_start,
    input  logic [7:0]                        i_key,
    input  tetris_pkg::board_t                i_board,
    input  logic [tetris_pkg::FIELD_ROWS-1:0] i_row_full,
    output tetris_pkg::board_cmd_t            o_cmd,
    output tetris_pkg::cells_t                o_active_cells,
    output tetris_pkg::color_code_t           o_active_code,
    output logic                              o_playing,
    output logic [7:0]                        o_score
);
    import tetris_pkg::*;

    localparam int GW = $clog2(GRAVITY_TICKS) + 2;
    localparam int SW = $clog2(SETTLE_TICKS) + 1;

    typedef enum logic [2:0] {
        S_IDLE,
        S_SETTLE,
        S_WAIT,
        S_DROP,
        S_PLACE,
        S_SCAN,
        S_SPAWN
    } state_t;

    state_t        state;
    piece_t        piece;
    piece_t        candidate;
    cells_t        active_cells;
    cells_t        cand_cells;
    logic          cand_fits;
    logic          cand_move;
    logic          cand_fall;
    logic [GW-1:0] grav_cnt;
    logic          grav_due;
    logic [SW-1:0] settle_cnt;
    row_t          scan_row;
    logic [2:0]    clear_cnt;
    logic [9:0]    score;
    logic [9:0]    points;
    logic [2:0]    next_shape;

    assign next_shape = (piece.shape == 3'd6) ? 3'd0 : piece.shape + 3'd1;
    assign grav_due   = grav_cnt >= GW'(GRAVITY_TICKS);
    // 1, 3, 5, 7 for one to four rows
    assign points     = (clear_cnt == 3'd0) ? 10'd0 : 10'({clear_cnt, 1'b0} - 4'd1);

    // candidate piece for this cycle
    always_comb begin
        candidate = piece;
        cand_move = 1'b0;
        cand_fall = 1'b0;
        case (state)
            S_IDLE: begin
                candidate = '{shape: 3'd0, dir: 2'd0, x: SPAWN_COL, y: SPAWN_ROW};
            end
            S_SPAWN: begin
                candidate = '{shape: next_shape, dir: 2'd0, x: SPAWN_COL, y: SPAWN_ROW};
            end
            S_DROP: begin
                candidate.y = piece.y + 5'd1;
            end
            S_WAIT: begin
                case (i_key)
                    KEY_LEFT: begin
                        candidate.x = piece.x - 4'd1;
                        cand_move   = 1'b1;
                    end
                    KEY_RIGHT: begin
                        candidate.x = piece.x + 4'd1;
                        cand_move   = 1'b1;
                    end
                    KEY_ROTATE: begin
                        candidate.dir = piece.dir + 2'd1;
                        cand_move     = 1'b1;
                    end
                    KEY_DROP: begin
                    end
                    default: begin
                        if (grav_due) begin
                            candidate.y = piece.y + 5'd1;
                            cand_move   = 1'b1;
                            cand_fall   = 1'b1;
                        end
                    end
                endcase
            end
            default: begin
            end
        endcase
    end

    piece_fit_checker fit_checker_inst (
        .i_piece (candidate),
        .i_board (i_board),
        .o_cells (cand_cells),
        .o_fits  (cand_fits)
    );

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            state        <= S_IDLE;
            piece        <= '0;
            active_cells <= '0;
            grav_cnt     <= '0;
            settle_cnt   <= '0;
            scan_row     <= '0;
            clear_cnt    <= '0;
            score        <= '0;
        end else begin
            case (state)
                S_IDLE: begin
                    if (i_start) begin
                        piece        <= candidate;
                        active_cells <= cand_cells;
                        grav_cnt     <= '0;
                        score        <= '0;
                        state        <= S_SETTLE;
                    end
                end
                S_SETTLE: begin
                    if (settle_cnt == SW'(SETTLE_TICKS - 1)) begin
                        settle_cnt <= '0;
                        state      <= S_WAIT;
                    end else begin
                        settle_cnt <= settle_cnt + SW'(1);
                    end
                end
                S_WAIT: begin
                    // saturates once a fall is due
                    if (!grav_due) begin
                        grav_cnt <= grav_cnt + ((i_key == KEY_FAST) ? GW'(FAST_STEP) : GW'(1));
                    end
                    if (i_key == KEY_DROP) begin
                        state <= S_DROP;
                    end else if (cand_move && cand_fits) begin
                        piece        <= candidate;
                        active_cells <= cand_cells;
                        state        <= S_SETTLE;
                        if (cand_fall) begin
                            grav_cnt <= '0;
                        end
                    end else if (cand_fall) begin
                        state <= S_PLACE;
                    end
                end
                S_DROP: begin
                    if (cand_fits) begin
                        piece        <= candidate;
                        active_cells <= cand_cells;
                        grav_cnt     <= '0;
                    end else begin
                        state <= S_PLACE;
                    end
                end
                S_PLACE: begin
                    scan_row  <= '0;
                    clear_cnt <= '0;
                    state     <= S_SCAN;
                end
                S_SCAN: begin
                    if (i_row_full[scan_row]) begin
                        clear_cnt <= clear_cnt + 3'd1;
                    end
                    if (scan_row == row_t'(FIELD_ROWS - 1)) begin
                        state <= S_SPAWN;
                    end else begin
                        scan_row <= scan_row + 5'd1;
                    end
                end
                S_SPAWN: begin
                    score    <= score + points;
                    grav_cnt <= '0;
                    if (cand_fits) begin
                        piece        <= candidate;
                        active_cells <= cand_cells;
                        state        <= S_SETTLE;
                    end else begin
                        // game over leaves the board visible
                        state <= S_IDLE;
                    end
                end
                default: begin
                    state <= S_IDLE;
                end
            endcase
        end
    end

    always_comb begin
        o_cmd.op    = OP_NONE;
        o_cmd.cells = active_cells;
        o_cmd.code  = o_active_code;
        o_cmd.row   = scan_row;
        case (state)
            S_IDLE: begin
                if (i_start) begin
                    o_cmd.op = OP_WIPE;
                end
            end
            S_PLACE: begin
                o_cmd.op = OP_PLACE;
            end
            S_SCAN: begin
                if (i_row_full[scan_row]) begin
                    o_cmd.op = OP_CLEAR_ROW;
                end
            end
            default: begin
            end
        endcase
    end

    assign o_active_cells = active_cells;
    assign o_active_code  = color_code_t'(piece.shape + 3'd1);
    assign o_playing      = (state != S_IDLE);
    assign o_score        = score[7:0];

endmodule

/* design/piece_fit_checker.sv */
`timescale 1ns/1ps

module piece_fit_checker (
    input  tetris_pkg::piece_t i_piece,
    input  tetris_pkg::board_t i_board,
    output tetris_pkg::cells_t o_cells,
    output logic               o_fits
);
    import tetris_pkg::*;

    always_comb begin
        int cx [4];
        int cy [4];

        cx[0] = int'(i_piece.x);
        cy[0] = int'(i_piece.y);
        for (int k = 0; k < 3; k++) begin
            cx[k+1] = cx[0] + SHAPE_OFFSETS[i_piece.shape][i_piece.dir][k][0];
            cy[k+1] = cy[0] + SHAPE_OFFSETS[i_piece.shape][i_piece.dir][k][1];
        end

        o_fits = 1'b1;
        for (int k = 0; k < 4; k++) begin
            o_cells[k].x = col_t'(cx[k]);
            o_cells[k].y = row_t'(cy[k]);
            // outside the field never fits
            if (cx[k] < 0 || cx[k] >= FIELD_COLS || cy[k] < 0 || cy[k] >= FIELD_ROWS) begin
                o_fits = 1'b0;
            end else if (i_board[cy[k]][cx[k]] != '0) begin
                o_fits = 1'b0;
            end
        end
    end

endmodule

/* design/tetris_pkg.sv */
package tetris_pkg;

    // field geometry
    localparam int FIELD_COLS = 10;
    localparam int FIELD_ROWS = 20;

    typedef logic [3:0] col_t;
    typedef logic [4:0] row_t;

    typedef struct packed {
        col_t x;
        row_t y;
    } cell_t;

    // index 0 is the piece centre
    typedef cell_t [3:0] cells_t;

    // 0 empty, otherwise shape + 1
    typedef logic [2:0] color_code_t;

    // row 0 is the top row
    typedef color_code_t [FIELD_ROWS-1:0][FIELD_COLS-1:0] board_t;

    typedef struct packed {
        logic [2:0] shape;
        logic [1:0] dir;
        col_t       x;
        row_t       y;
    } piece_t;

    // (dx, dy) of the three cells around the centre, per shape and direction
    localparam int SHAPE_OFFSETS [7][4][3][2] = '{
        '{'{'{-1, 0}, '{ 0, 1}, '{ 1, 1}},
          '{'{ 0,-1}, '{-1, 0}, '{-1, 1}},
          '{'{-1, 0}, '{ 0, 1}, '{ 1, 1}},
          '{'{ 0,-1}, '{-1, 0}, '{-1, 1}}},
        '{'{'{-1, 1}, '{ 0, 1}, '{ 1, 0}},
          '{'{-1,-1}, '{-1, 0}, '{ 0, 1}},
          '{'{-1, 1}, '{ 0, 1}, '{ 1, 0}},
          '{'{-1,-1}, '{-1, 0}, '{ 0, 1}}},
        '{'{'{-1, 0}, '{ 0, 1}, '{ 1, 0}},
          '{'{-1, 0}, '{ 0,-1}, '{ 0, 1}},
          '{'{-1, 0}, '{ 0,-1}, '{ 1, 0}},
          '{'{ 0,-1}, '{ 1, 0}, '{ 0, 1}}},
        '{'{'{-1, 0}, '{ 1, 0}, '{ 2, 0}},
          '{'{ 0,-1}, '{ 0, 1}, '{ 0, 2}},
          '{'{-1, 0}, '{ 1, 0}, '{ 2, 0}},
          '{'{ 0,-1}, '{ 0, 1}, '{ 0, 2}}},
        '{'{'{-1, 0}, '{ 1, 0}, '{ 1, 1}},
          '{'{-1, 1}, '{ 0,-1}, '{ 0, 1}},
          '{'{-1,-1}, '{-1, 0}, '{ 1, 0}},
          '{'{ 0,-1}, '{ 0, 1}, '{ 1,-1}}},
        '{'{'{-1, 0}, '{-1, 1}, '{ 1, 0}},
          '{'{-1,-1}, '{ 0,-1}, '{ 0, 1}},
          '{'{-1, 0}, '{ 1, 0}, '{ 1,-1}},
          '{'{ 0,-1}, '{ 0, 1}, '{ 1, 1}}},
        '{'{'{ 0, 1}, '{ 1, 0}, '{ 1, 1}},
          '{'{ 0, 1}, '{ 1, 0}, '{ 1, 1}},
          '{'{ 0, 1}, '{ 1, 0}, '{ 1, 1}},
          '{'{ 0, 1}, '{ 1, 0}, '{ 1, 1}}}
    };

    typedef enum logic [1:0] {
        OP_NONE,
        OP_WIPE,
        OP_PLACE,
        OP_CLEAR_ROW
    } board_op_t;

    typedef struct packed {
        board_op_t   op;
        cells_t      cells;
        color_code_t code;
        row_t        row;
    } board_cmd_t;

    typedef struct packed {
        logic [7:0] r;
        logic [7:0] g;
        logic [7:0] b;
    } rgb_t;

    // keyboard scan codes
    localparam logic [7:0] KEY_ROTATE = 8'h75;
    localparam logic [7:0] KEY_DROP   = 8'h29;
    localparam logic [7:0] KEY_RIGHT  = 8'h74;
    localparam logic [7:0] KEY_LEFT   = 8'h6b;
    localparam logic [7:0] KEY_FAST   = 8'h72;

    localparam col_t SPAWN_COL = 4'd4;
    localparam row_t SPAWN_ROW = 5'd0;
    localparam int   FAST_STEP = 5;

    // screen placement of the field
    localparam int FIELD_X0 = 230;
    localparam int FIELD_Y0 = 40;
    localparam int CELL_W   = 18;
    localparam int CELL_H   = 20;

    localparam logic [7:0] GRID_LEVEL  = 8'd255;
    localparam logic [7:0] BACK_LEVEL  = 8'd50;
    localparam logic [7:0] EMPTY_LEVEL = 8'd20;

    // entry 0 is the empty cell
    localparam rgb_t PALETTE [8] = '{
        '{EMPTY_LEVEL, EMPTY_LEVEL, EMPTY_LEVEL},
        '{8'd255, 8'd20,  8'd20 },
        '{8'd20,  8'd255, 8'd20 },
        '{8'd20,  8'd20,  8'd255},
        '{8'd20,  8'd255, 8'd255},
        '{8'd255, 8'd20,  8'd255},
        '{8'd255, 8'd255, 8'd20 },
        '{8'd255, 8'd100, 8'd0  }
    };

endpackage

/* design/tetris_top.sv */
`timescale 1ns/1ps

module tetris_top #(
    parameter int GRAVITY_TICKS = 1 << 24,
    parameter int SETTLE_TICKS  = 1 << 22
) (
    input  logic             i_clk,
    input  logic             i_rst_n,
    input  logic             i_start,
    input  logic [7:0]       i_key,
    input  logic [9:0]       i_x,
    input  logic [9:0]       i_y,
    output tetris_pkg::rgb_t o_rgb,
    output logic [7:0]       o_score,
    output logic             o_playing
);
    import tetris_pkg::*;

    board_cmd_t            board_cmd;
    board_t                board;
    logic [FIELD_ROWS-1:0] row_full;
    cells_t                active_cells;
    color_code_t           active_code;

    piece_controller #(
        .GRAVITY_TICKS (GRAVITY_TICKS),
        .SETTLE_TICKS  (SETTLE_TICKS)
    ) piece_controller_inst (
        .i_clk          (i_clk),
        .i_rst_n        (i_rst_n),
        .i_start        (i_start),
        .i_key          (i_key),
        .i_board        (board),
        .i_row_full     (row_full),
        .o_cmd          (board_cmd),
        .o_active_cells (active_cells),
        .o_active_code  (active_code),
        .o_playing      (o_playing),
        .o_score        (o_score)
    );

    board_store board_store_inst (
        .i_clk      (i_clk),
        .i_rst_n    (i_rst_n),
        .i_cmd      (board_cmd),
        .o_board    (board),
        .o_row_full (row_full)
    );

    field_renderer field_renderer_inst (
        .i_clk          (i_clk),
        .i_rst_n        (i_rst_n),
        .i_x            (i_x),
        .i_y            (i_y),
        .i_board        (board),
        .i_active_cells (active_cells),
        .i_active_code  (active_code),
        .i_playing      (o_playing),
        .o_rgb          (o_rgb)
    );

endmodule

/* run_sim.sh */
#!/bin/sh
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 --top-module tetris_tb -f tetris.f -o tetris_sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

output=$(./obj_dir/tetris_sim)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -qx "TB PASSED"; then
    exit 0
fi
echo "pass line not found in simulation output"
exit 1

/* tb/tetris_tb_tasks.svh */
// inputs change 2 ns after the rising edge
task automatic step();
    @(posedge clk);
    #2;
endtask

task automatic check_int(int got, int exp, string what);
    checks++;
    assert (got == exp) else begin
        errors++;
        $display("Mismatch at %0t: %s got %0d expected %0d", $time, what, got, exp);
    end
endtask

task automatic check_range(int got, int lo, int hi, string what);
    checks++;
    assert (got >= lo && got < hi) else begin
        errors++;
        $display("Mismatch at %0t: %s got %0d expected %0d to %0d", $time, what, got, lo, hi - 1);
    end
endtask

task automatic check_rgb(logic [23:0] got, logic [23:0] exp, string what);
    checks++;
    assert (got == exp) else begin
        errors++;
        $display("Mismatch at %0t: %s got %06h expected %06h", $time, what, got, exp);
    end
endtask

task automatic check_true(bit cond, string what);
    checks++;
    assert (cond) else begin
        errors++;
        $display("error at %0t: %s", $time, what);
    end
endtask

task automatic report_test(string name, int prev);
    $display("test %-16s %s, %0d errors", name, (errors == prev) ? "ok" : "failed", errors - prev);
endtask

function automatic int cell_col(int shape, int dir, int x, int k);
    int c;
    c = x;
    if (k > 0) begin
        c = x + SHAPE_OFFSETS[shape][dir][k-1][0];
    end
    return c;
endfunction

function automatic int cell_row(int shape, int dir, int y, int k);
    int r;
    r = y;
    if (k > 0) begin
        r = y + SHAPE_OFFSETS[shape][dir][k-1][1];
    end
    return r;
endfunction

function automatic bit piece_fits(int shape, int dir, int x, int y);
    int c;
    int r;
    bit ok;
    ok = 1'b1;
    for (int k = 0; k < 4; k++) begin
        c = cell_col(shape, dir, x, k);
        r = cell_row(shape, dir, y, k);
        if (c < 0 || c >= FIELD_COLS || r < 0 || r >= FIELD_ROWS) begin
            ok = 1'b0;
        end else if (model_board[r][c] != 0) begin
            ok = 1'b0;
        end
    end
    return ok;
endfunction

function automatic bit piece_covers(int c, int r);
    bit hit;
    hit = 1'b0;
    for (int k = 0; k < 4; k++) begin
        if (cell_col(cur_shape, cur_dir, cur_x, k) == c
                && cell_row(cur_shape, cur_dir, cur_y, k) == r) begin
            hit = 1'b1;
        end
    end
    return hit;
endfunction

function automatic bit row_is_full(int r);
    bit full;
    full = 1'b1;
    for (int c = 0; c < FIELD_COLS; c++) begin
        if (model_board[r][c] == 0) begin
            full = 1'b0;
        end
    end
    return full;
endfunction

function automatic rgb_t cell_colour(int c, int r, bit show_piece);
    rgb_t col;
    col = PALETTE[model_board[r][c]];
    if (show_piece && piece_covers(c, r)) begin
        col = PALETTE[cur_shape + 1];
    end
    return col;
endfunction

task automatic clear_model();
    for (int r = 0; r < FIELD_ROWS; r++) begin
        for (int c = 0; c < FIELD_COLS; c++) begin
            model_board[r][c] = 0;
        end
    end
    model_score   = 0;
    cur_shape     = 0;
    cur_dir       = 0;
    cur_x         = int'(SPAWN_COL);
    cur_y         = int'(SPAWN_ROW);
    model_playing = 1'b0;
endtask

task automatic check_pixel(int px, int py, logic [23:0] exp, string what);
    pix_x = 10'(px);
    pix_y = 10'(py);
    step();
    check_rgb(rgb, exp, what);
endtask

task automatic set_cell_pixel(int c, int r);
    pix_x = 10'(FIELD_X0 + c * CELL_W + CELL_W / 2);
    pix_y = 10'(FIELD_Y0 + r * CELL_H + CELL_H / 2);
endtask

task automatic read_cell(int c, int r, logic [23:0] exp, string what);
    set_cell_pixel(c, r);
    step();
    check_rgb(rgb, exp, $sformatf("%s cell (%0d,%0d)", what, c, r));
endtask

task automatic check_piece();
    for (int k = 0; k < 4; k++) begin
        read_cell(cell_col(cur_shape, cur_dir, cur_x, k), cell_row(cur_shape, cur_dir, cur_y, k),
                  PALETTE[cur_shape + 1], "piece");
    end
endtask

task automatic check_board();
    for (int r = 0; r < FIELD_ROWS; r++) begin
        for (int c = 0; c < FIELD_COLS; c++) begin
            read_cell(c, r, cell_colour(c, r, model_playing), "board");
        end
    end
endtask

task automatic start_pulse();
    start = 1'b1;
    step();
    start = 1'b0;
    clear_model();
    model_playing = 1'b1;
endtask

// one-cycle key pulse once the piece has settled
task automatic key_pulse(logic [7:0] k);
    repeat (2 * SETTLE_TICKS) step();
    key = k;
    step();
    key = 8'h00;
endtask

task automatic press_move(logic [7:0] k, int dx, int ddir);
    key_pulse(k);
    if (piece_fits(cur_shape, (cur_dir + ddir) % 4, cur_x + dx, cur_y)) begin
        cur_x   = cur_x + dx;
        cur_dir = (cur_dir + ddir) % 4;
    end
endtask

// watches the cell under the lowest piece cell
task automatic wait_for_fall(int limit, output int waited);
    int low_k;
    low_k = 0;
    for (int k = 1; k < 4; k++) begin
        if (cell_row(cur_shape, cur_dir, cur_y, k) > cell_row(cur_shape, cur_dir, cur_y, low_k)) begin
            low_k = k;
        end
    end
    set_cell_pixel(cell_col(cur_shape, cur_dir, cur_x, low_k),
                   cell_row(cur_shape, cur_dir, cur_y, low_k) + 1);
    waited = 0;
    step();
    while (rgb != PALETTE[cur_shape + 1] && waited < limit) begin
        step();
        waited++;
    end
    cur_y = cur_y + 1;
endtask

task automatic model_landing();
    int cleared;
    cleared = 0;
    while (piece_fits(cur_shape, cur_dir, cur_x, cur_y + 1)) begin
        cur_y++;
    end
    for (int k = 0; k < 4; k++) begin
        model_board[cell_row(cur_shape, cur_dir, cur_y, k)][cell_col(cur_shape, cur_dir, cur_x, k)]
            = cur_shape + 1;
    end
    // scan top to bottom and move the rows above a full one down
    for (int r = 0; r < FIELD_ROWS; r++) begin
        if (row_is_full(r)) begin
            for (int s = r; s > 0; s--) begin
                for (int c = 0; c < FIELD_COLS; c++) begin
                    model_board[s][c] = model_board[s-1][c];
                end
            end
            for (int c = 0; c < FIELD_COLS; c++) begin
                model_board[0][c] = 0;
            end
            cleared++;
        end
    end
    model_score   = model_score + CLEAR_POINTS[cleared];
    cur_shape     = (cur_shape + 1) % 7;
    cur_dir       = 0;
    cur_x         = int'(SPAWN_COL);
    cur_y         = int'(SPAWN_ROW);
    model_playing = piece_fits(cur_shape, cur_dir, cur_x, cur_y);
endtask

task automatic drop_piece(int n);
    int          min_dx;
    int          max_dx;
    int          dx;
    int          target;
    int          steps;
    int          waited;
    int unsigned rnd;
    min_dx = 0;
    max_dx = 0;
    for (int k = 0; k < 3; k++) begin
        dx = SHAPE_OFFSETS[cur_shape][cur_dir][k][0];
        min_dx = (dx < min_dx) ? dx : min_dx;
        max_dx = (dx > max_dx) ? dx : max_dx;
    end
    rnd    = $random(seed);
    target = -min_dx + int'(rnd % (FIELD_COLS - max_dx + min_dx));
    steps  = target - cur_x;
    while (steps != 0) begin
        if (steps < 0) begin
            press_move(KEY_LEFT, -1, 0);
            steps++;
        end else begin
            press_move(KEY_RIGHT, 1, 0);
            steps--;
        end
    end
    key_pulse(KEY_DROP);
    model_landing();
    // landing is over once the next shape shows at the spawn centre
    set_cell_pixel(int'(SPAWN_COL), int'(SPAWN_ROW));
    waited = 0;
    step();
    while (playing && rgb != PALETTE[cur_shape + 1] && waited < LANDING_LIMIT) begin
        step();
        waited++;
    end
    check_true(waited < LANDING_LIMIT,
               $sformatf("landing %0d did not end within %0d cycles", n, LANDING_LIMIT));
    check_int(int'(playing), int'(model_playing), $sformatf("o_playing after landing %0d", n));
    check_board();
    check_int(int'(score), model_score % 256, $sformatf("o_score after landing %0d", n));
endtask

task automatic test_reset_start();
    rst_n = 1'b0;
    repeat (4) step();
    check_int(int'(playing), 0, "o_playing in reset");
    check_int(int'(score), 0, "o_score in reset");
    check_rgb(rgb, 24'h0, "o_rgb in reset");
    rst_n = 1'b1;
    step();
    check_int(int'(playing), 0, "o_playing after reset");
    check_int(int'(score), 0, "o_score after reset");
    // idle field is empty with no active piece shown
    check_board();
    start_pulse();
    check_int(int'(playing), 1, "o_playing after start");
    check_board();
    check_pixel(FIELD_X0, FIELD_Y0 + CELL_H / 2, {GRID_LEVEL, GRID_LEVEL, GRID_LEVEL}, "grid line");
    check_pixel(10, 10, {BACK_LEVEL, BACK_LEVEL, BACK_LEVEL}, "outside pixel");
endtask

task automatic test_movement();
    repeat (5) begin
        press_move(KEY_LEFT, -1, 0);
        check_piece();
    end
    repeat (FIELD_COLS - 1) begin
        press_move(KEY_RIGHT, 1, 0);
        check_piece();
    end
endtask

task automatic test_rotation();
    int waited;
    // top cell would leave the field
    press_move(KEY_ROTATE, 0, 1);
    check_piece();
    wait_for_fall(GRAVITY_TICKS + FALL_MARGIN, waited);
    check_true(waited < GRAVITY_TICKS + FALL_MARGIN, "piece did not fall under gravity");
    check_piece();
    press_move(KEY_ROTATE, 0, 1);
    check_piece();
endtask

task automatic test_gravity();
    int waited;
    wait_for_fall(GRAVITY_TICKS + FALL_MARGIN, waited);
    check_range(waited, GRAVITY_TICKS - FALL_MARGIN, GRAVITY_TICKS + FALL_MARGIN,
                "cycles to gravity fall");
    check_piece();
    key = KEY_FAST;
    wait_for_fall(GRAVITY_TICKS / FAST_STEP + FALL_MARGIN, waited);
    key = 8'h00;
    check_range(waited, GRAVITY_TICKS / FAST_STEP - FALL_MARGIN,
                GRAVITY_TICKS / FAST_STEP + FALL_MARGIN, "cycles to fast fall");
    check_piece();
endtask

task automatic test_drops();
    int drops;
    drops = 0;
    while (model_playing && drops < MAX_DROPS) begin
        drops++;
        drop_piece(drops);
    end
    check_true(!model_playing, $sformatf("game still running after %0d drops", MAX_DROPS));
endtask

task automatic test_game_over();
    check_int(int'(playing), 0, "o_playing after game over");
    repeat (2) step();
    check_int(int'(playing), 0, "o_playing while idle");
    start_pulse();
    check_int(int'(playing), 1, "o_playing after restart");
    check_int(int'(score), 0, "o_score after restart");
    check_board();
endtask

/* tb/tetris_tb.sv */
`timescale 1ns/1ps

module tetris_tb;
    import tetris_pkg::*;

    localparam int GRAVITY_TICKS = 6000;
    localparam int SETTLE_TICKS  = 4;
    localparam int CLK_PERIOD    = 40;
    localparam int FALL_MARGIN   = 64;
    localparam int LANDING_LIMIT = 2 * FIELD_ROWS + 24;
    localparam int MAX_DROPS     = 250;
    // board read, column moves, drop, place, scan and settle of one piece
    localparam int LANDING_CYCLES = FIELD_ROWS * FIELD_COLS
                                  + FIELD_COLS * (2 * SETTLE_TICKS + 1)
                                  + LANDING_LIMIT + SETTLE_TICKS;
    localparam int TIMEOUT_CYCLES = MAX_DROPS * LANDING_CYCLES + 3 * GRAVITY_TICKS + 2000;
    localparam int CLEAR_POINTS [5] = '{0, 1, 3, 5, 7};

    logic       clk;
    logic       rst_n;
    logic       start;
    logic [7:0] key;
    logic [9:0] pix_x;
    logic [9:0] pix_y;
    rgb_t       rgb;
    logic [7:0] score;
    logic       playing;

    // reference model of the game
    int model_board [FIELD_ROWS][FIELD_COLS];
    int cur_shape;
    int cur_dir;
    int cur_x;
    int cur_y;
    int model_score;
    bit model_playing;

    int     errors;
    int     checks;
    int     cycle_cnt = 0;
    integer seed;

    tetris_top #(
        .GRAVITY_TICKS (GRAVITY_TICKS),
        .SETTLE_TICKS  (SETTLE_TICKS)
    ) tetris_top_inst (
        .i_clk     (clk),
        .i_rst_n   (rst_n),
        .i_start   (start),
        .i_key     (key),
        .i_x       (pix_x),
        .i_y       (pix_y),
        .o_rgb     (rgb),
        .o_score   (score),
        .o_playing (playing)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #(CLK_PERIOD / 2) clk = ~clk;
        end
    end

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= TIMEOUT_CYCLES) begin
            $display("timeout: run stopped after %0d cycles without finishing", cycle_cnt);
            $display("TB FAILED");
            $finish;
        end
    end

    `include "tetris_tb_tasks.svh"

    initial begin
        int prev;

        seed   = 32'h2299;
        errors = 0;
        checks = 0;
        rst_n  = 1'b0;
        start  = 1'b0;
        key    = 8'h00;
        pix_x  = '0;
        pix_y  = '0;
        clear_model();

        prev = errors;
        test_reset_start();
        report_test("reset and start", prev);

        prev = errors;
        test_movement();
        report_test("movement limits", prev);

        prev = errors;
        test_rotation();
        report_test("rotation", prev);

        prev = errors;
        test_gravity();
        report_test("gravity", prev);

        prev = errors;
        test_drops();
        report_test("drops and score", prev);

        prev = errors;
        test_game_over();
        report_test("game over", prev);

        $display("summary: %0d checks, %0d errors, %0d cycles", checks, errors, cycle_cnt);
        if (errors == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

/* tetris.f */
+incdir+tb
design/tetris_pkg.sv
design/piece_fit_checker.sv
design/board_store.sv
design/piece_controller.sv
design/field_renderer.sv
design/tetris_top.sv
tb/tetris_tb.sv
